// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_clk_mon -f project.f

run: compile
	./obj_dir/Vtb_clk_mon | tee $(LOG)
	@grep -q "sim passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/clk_mon.sv ====
`timescale 1ns/1ns
`default_nettype none

module clk_mon (
    input  wire                         clk_ref,
    input  wire                         reset,
    input  wire clk_mon_pkg::ch_mask_t  clk_test,
    input  wire clk_mon_pkg::ch_mask_t  locked,
    input  wire clk_mon_pkg::ce_t       bus_rd_ce,
    input  wire clk_mon_pkg::ce_t       bus_wr_ce,
    input  wire clk_mon_pkg::reg_word_t bus_wdata,
    output clk_mon_pkg::reg_word_t      rdata,
    output logic                        rd_ack,
    output logic                        wr_ack
);

    import clk_mon_pkg::*;

    //////////////////////////////////////////////////
    // Inter-stage wires
    //////////////////////////////////////////////////

    ch_mask_t test_sync;
    ch_mask_t locked_sync;
    ch_mask_t unlock_clear;
    rate_t    rate [NUM_CH];
    count_t   unlocks [NUM_CH];

    // Crossing into clk_ref
    input_sync u_input_sync (
        .clk_ref     (clk_ref),
        .reset       (reset),
        .clk_test    (clk_test),
        .locked      (locked),
        .test_sync   (test_sync),
        .locked_sync (locked_sync)
    );

    rate_meter u_rate_meter (
        .clk_ref   (clk_ref),
        .reset     (reset),
        .test_sync (test_sync),
        .rate      (rate)
    );

    unlock_counter u_unlock_counter (
        .clk_ref      (clk_ref),
        .reset        (reset),
        .locked_sync  (locked_sync),
        .unlock_clear (unlock_clear),
        .unlocks      (unlocks)
    );

    // IPIF-style register access
    reg_access u_reg_access (
        .clk_ref      (clk_ref),
        .reset        (reset),
        .bus_rd_ce    (bus_rd_ce),
        .bus_wr_ce    (bus_wr_ce),
        .bus_wdata    (bus_wdata),
        .rate         (rate),
        .unlocks      (unlocks),
        .locked_sync  (locked_sync),
        .unlock_clear (unlock_clear),
        .rdata        (rdata),
        .rd_ack       (rd_ack),
        .wr_ack       (wr_ack)
    );

endmodule

`default_nettype wire

// ==== design/clk_mon_pkg.sv ====
`default_nettype none

package clk_mon_pkg;

    //////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////

    // Monitored clock/lock pairs
    localparam int NUM_CH = 4;

    // Bus words per channel
    localparam int REGS_PER_CH = 4;

    // Rate measurement window, in clk_ref cycles
    localparam int WINDOW_CYCLES = 64;

    //////////////////////////////////////////////////
    // Register map within one channel
    //////////////////////////////////////////////////

    localparam int REG_RATE     = 0;
    localparam int REG_UNLOCKS  = 1;
    localparam int REG_STATUS   = 2;
    localparam int REG_RESERVED = 3;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [31:0] reg_word_t;
    typedef logic [31:0] rate_t;
    typedef logic [31:0] count_t;
    typedef logic [15:0] window_t;
    typedef logic [NUM_CH-1:0] ch_mask_t;

    // Chip enables, bit ch*REGS_PER_CH + reg
    typedef logic [NUM_CH*REGS_PER_CH-1:0] ce_t;

endpackage

`default_nettype wire

// ==== design/input_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module input_sync (
    input  wire                        clk_ref,
    input  wire                        reset,
    input  wire clk_mon_pkg::ch_mask_t clk_test,
    input  wire clk_mon_pkg::ch_mask_t locked,
    output clk_mon_pkg::ch_mask_t      test_sync,
    output clk_mon_pkg::ch_mask_t      locked_sync
);

    import clk_mon_pkg::*;

    // First stage, may go metastable
    ch_mask_t test_meta;
    ch_mask_t locked_meta;

    // Two flops per bit, the only entry into clk_ref
    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            test_meta   <= '0;
            locked_meta <= '0;
            test_sync   <= '0;
            locked_sync <= '0;
        end
        else
        begin
            test_meta   <= clk_test;
            locked_meta <= locked;
            test_sync   <= test_meta;
            locked_sync <= locked_meta;
        end
    end

endmodule

`default_nettype wire

// ==== design/rate_meter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rate_meter (
    input  wire                        clk_ref,
    input  wire                        reset,
    input  wire clk_mon_pkg::ch_mask_t test_sync,
    output clk_mon_pkg::rate_t         rate [clk_mon_pkg::NUM_CH]
);

    import clk_mon_pkg::*;

    // Previous level for edge detect
    ch_mask_t test_prev;
    ch_mask_t test_rise;

    // Shared window position
    window_t window_cnt;
    logic    window_end;

    // Edges seen so far in the running window
    rate_t edge_cnt [NUM_CH];

    assign test_rise  = test_sync & ~test_prev;
    assign window_end = (window_cnt == window_t'(WINDOW_CYCLES - 1));

    //////////////////////////////////////////////////
    // Window timing
    //////////////////////////////////////////////////

    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            window_cnt <= '0;
            test_prev  <= '0;
        end
        else
        begin
            test_prev <= test_sync;
            if (window_end)
                window_cnt <= '0;
            else
                window_cnt <= window_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Per-channel edge count and hold
    //////////////////////////////////////////////////

    always_ff @(posedge clk_ref)
    begin
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            if (reset)
            begin
                edge_cnt[ch] <= '0;
                rate[ch]     <= '0;
            end
            else if (window_end)
            begin
                rate[ch] <= edge_cnt[ch];
                // Edge in the last cycle opens the next window
                edge_cnt[ch] <= rate_t'(test_rise[ch]);
            end
            else
            begin
                edge_cnt[ch] <= edge_cnt[ch] + rate_t'(test_rise[ch]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_access.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_access (
    input  wire                         clk_ref,
    input  wire                         reset,
    input  wire clk_mon_pkg::ce_t       bus_rd_ce,
    input  wire clk_mon_pkg::ce_t       bus_wr_ce,
    input  wire clk_mon_pkg::reg_word_t bus_wdata,
    input  wire clk_mon_pkg::rate_t     rate [clk_mon_pkg::NUM_CH],
    input  wire clk_mon_pkg::count_t    unlocks [clk_mon_pkg::NUM_CH],
    input  wire clk_mon_pkg::ch_mask_t  locked_sync,
    output clk_mon_pkg::ch_mask_t       unlock_clear,
    output clk_mon_pkg::reg_word_t      rdata,
    output logic                        rd_ack,
    output logic                        wr_ack
);

    import clk_mon_pkg::*;

    // Strobed channel and register
    int rd_ch;
    int rd_reg;

    reg_word_t rd_word;
    ch_mask_t  clear_next;

    //////////////////////////////////////////////////
    // Chip-enable decode
    //////////////////////////////////////////////////

    // At most one enable is high, so the last hit is the only one
    always_comb
    begin
        rd_ch  = 0;
        rd_reg = REG_RESERVED;
        for (int i = 0; i < NUM_CH * REGS_PER_CH; i++)
        begin
            if (bus_rd_ce[i])
            begin
                rd_ch  = i / REGS_PER_CH;
                rd_reg = i % REGS_PER_CH;
            end
        end
    end

    // Read word, zero when nothing is strobed
    always_comb
    begin
        rd_word = '0;
        if (|bus_rd_ce)
        begin
            case (rd_reg)
                REG_RATE:     rd_word = rate[rd_ch];
                REG_UNLOCKS:  rd_word = unlocks[rd_ch];
                REG_STATUS:   rd_word = reg_word_t'(locked_sync[rd_ch]);
                REG_RESERVED: rd_word = '0;
                default:      rd_word = '0;
            endcase
        end
    end

    // Write data has no stored field, a write to the unlocks word clears it
    always_comb
    begin
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            clear_next[ch] = bus_wr_ce[ch * REGS_PER_CH + REG_UNLOCKS];
        end
    end

    //////////////////////////////////////////////////
    // Registered response
    //////////////////////////////////////////////////

    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            rdata        <= '0;
            rd_ack       <= 1'b0;
            wr_ack       <= 1'b0;
            unlock_clear <= '0;
        end
        else
        begin
            rdata        <= rd_word;
            rd_ack       <= |bus_rd_ce;
            wr_ack       <= |bus_wr_ce;
            unlock_clear <= clear_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/unlock_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module unlock_counter (
    input  wire                        clk_ref,
    input  wire                        reset,
    input  wire clk_mon_pkg::ch_mask_t locked_sync,
    input  wire clk_mon_pkg::ch_mask_t unlock_clear,
    output clk_mon_pkg::count_t        unlocks [clk_mon_pkg::NUM_CH]
);

    import clk_mon_pkg::*;

    ch_mask_t locked_prev;
    ch_mask_t lock_fall;

    // High to low of the lock flag is one loss
    assign lock_fall = locked_prev & ~locked_sync;

    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            locked_prev <= '0;
            for (int ch = 0; ch < NUM_CH; ch++)
            begin
                unlocks[ch] <= '0;
            end
        end
        else
        begin
            locked_prev <= locked_sync;
            for (int ch = 0; ch < NUM_CH; ch++)
            begin
                // Clear beats a same-cycle loss
                if (unlock_clear[ch])
                    unlocks[ch] <= '0;
                // Saturate at all ones
                else if (lock_fall[ch] && (unlocks[ch] != '1))
                    unlocks[ch] <= unlocks[ch] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/clk_mon_pkg.sv
design/input_sync.sv
design/rate_meter.sv
design/unlock_counter.sv
design/reg_access.sv
design/clk_mon.sv
testbench/tb_clk_mon.sv

// ==== testbench/clk_mon_patterns.txt ====
# op ch reg|value expect(hex). H half period, L lock level, W wait cycles, R read and compare
# X write, D random lock drops, N read against drop count, Z read all as zero, T end of test
Z
T 1
H 0 1
H 1 2
H 2 4
H 3 8
W 140
R 0 0 20
R 1 0 10
R 2 0 8
R 3 0 4
T 2
H 2 16
W 140
R 2 0 2
R 0 0 20
R 1 0 10
R 3 0 4
T 3
L 1 1
L 3 1
W 8
L 3 0
D 1
N 1 1
R 1 2 1
L 1 0
W 8
R 1 2 0
T 4
X 1 1
R 1 1 0
R 3 1 1
X 0 0
R 0 0 20
R 0 3 0
T 5

// ==== testbench/tb_clk_mon.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_mon;

    import clk_mon_pkg::*;

    logic      clk_ref;
    logic      reset;
    ch_mask_t  clk_test = '0;
    ch_mask_t  locked;
    ce_t       bus_rd_ce;
    ce_t       bus_wr_ce;
    reg_word_t bus_wdata;
    reg_word_t rdata;
    logic      rd_ack;
    logic      wr_ack;

    // Test clock half periods in clk_ref cycles
    // Zero holds the clock at its level
    int half [NUM_CH] = '{default: 0};
    int phase [NUM_CH] = '{default: 0};

    int seed = 43;
    int drop_count = 0;
    int checks = 0;
    int errors = 0;
    int mark_checks = 0;
    int mark_errors = 0;
    int tests = 0;

    clk_mon UUT (
        .clk_ref   (clk_ref),
        .reset     (reset),
        .clk_test  (clk_test),
        .locked    (locked),
        .bus_rd_ce (bus_rd_ce),
        .bus_wr_ce (bus_wr_ce),
        .bus_wdata (bus_wdata),
        .rdata     (rdata),
        .rd_ack    (rd_ack),
        .wr_ack    (wr_ack)
    );

    initial
    begin
        clk_ref = 1'b0;
        forever #2 clk_ref = ~clk_ref;
    end

    // Per-channel test clock generators
    always @(posedge clk_ref)
    begin
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            if (half[ch] > 0)
            begin
                if (phase[ch] >= half[ch] - 1)
                begin
                    phase[ch]    <= 0;
                    clk_test[ch] <= ~clk_test[ch];
                end
                else
                    phase[ch] <= phase[ch] + 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus access
    //////////////////////////////////////////////////

    task automatic read_check(input int ch, input int rg, input reg_word_t expect_val);
        int waited;
        @(posedge clk_ref);
        bus_rd_ce <= ce_t'(1) << (ch * REGS_PER_CH + rg);
        @(posedge clk_ref);
        bus_rd_ce <= '0;
        @(negedge clk_ref);
        waited = 1;
        while (!rd_ack && waited < 4)
        begin
            @(negedge clk_ref);
            waited++;
        end
        checks++;
        if (!rd_ack)
        begin
            $display("Error: no read acknowledge within 4 cycles, channel %0d register %0d",
                     ch, rg);
            errors++;
        end
        else if (rdata !== expect_val)
        begin
            $display("Fail: rdata channel %0d register %0d got 0x%08h expected 0x%08h",
                     ch, rg, rdata, expect_val);
            errors++;
        end
        // Acknowledge lasts exactly one cycle
        @(negedge clk_ref);
        if (rd_ack)
        begin
            $display("Error: read acknowledge held longer than one cycle");
            errors++;
        end
    endtask

    task automatic write_strobe(input int ch, input int rg);
        int waited;
        @(posedge clk_ref);
        bus_wr_ce <= ce_t'(1) << (ch * REGS_PER_CH + rg);
        bus_wdata <= '1;
        @(posedge clk_ref);
        bus_wr_ce <= '0;
        bus_wdata <= '0;
        @(negedge clk_ref);
        waited = 1;
        while (!wr_ack && waited < 4)
        begin
            @(negedge clk_ref);
            waited++;
        end
        checks++;
        if (!wr_ack)
        begin
            $display("Error: no write acknowledge within 4 cycles, channel %0d register %0d",
                     ch, rg);
            errors++;
        end
        @(negedge clk_ref);
        if (wr_ack)
        begin
            $display("Error: write acknowledge held longer than one cycle");
            errors++;
        end
    endtask

    // Random number of lock losses with drops and restores at least 4 cycles long
    task automatic drop_lock(input int ch);
        drop_count = int'($unsigned($random(seed)) % 7) + 1;
        repeat (drop_count)
        begin
            @(posedge clk_ref);
            locked[ch] <= 1'b0;
            repeat (4) @(posedge clk_ref);
            locked[ch] <= 1'b1;
            repeat (4) @(posedge clk_ref);
        end
    endtask

    // Malformed pattern lines count as errors
    task automatic fields_check(input logic [7:0] op, input int got, input int want);
        if (got != want)
        begin
            $display("Error: pattern line '%c' has %0d fields where %0d are needed",
                     op, got, want);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Pattern interpreter
    //////////////////////////////////////////////////

    initial
    begin
        logic [7:0]       op;
        logic [8*128-1:0] line;
        int               fd;
        int               a;
        int               b;
        int               n_args;
        reg_word_t        expect_val;

        reset     = 1'b1;
        locked    = '0;
        bus_rd_ce = '0;
        bus_wr_ce = '0;
        bus_wdata = '0;
        repeat (5) @(posedge clk_ref);
        reset <= 1'b0;

        fd = $fopen("testbench/clk_mon_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Error: pattern file could not be opened");
            errors++;
        end
        else
        begin
            while ($fscanf(fd, " %c", op) == 1)
            begin
                case (op)
                    "H":
                    begin
                        n_args = $fscanf(fd, "%d %d", a, b);
                        fields_check(op, n_args, 2);
                        @(posedge clk_ref);
                        half[a] <= b;
                    end
                    "L":
                    begin
                        n_args = $fscanf(fd, "%d %d", a, b);
                        fields_check(op, n_args, 2);
                        @(posedge clk_ref);
                        locked[a] <= b[0];
                    end
                    "W":
                    begin
                        n_args = $fscanf(fd, "%d", a);
                        fields_check(op, n_args, 1);
                        repeat (a) @(posedge clk_ref);
                    end
                    "R":
                    begin
                        n_args = $fscanf(fd, "%d %d %h", a, b, expect_val);
                        fields_check(op, n_args, 3);
                        read_check(a, b, expect_val);
                    end
                    "N":
                    begin
                        n_args = $fscanf(fd, "%d %d", a, b);
                        fields_check(op, n_args, 2);
                        read_check(a, b, reg_word_t'(drop_count));
                    end
                    "X":
                    begin
                        n_args = $fscanf(fd, "%d %d", a, b);
                        fields_check(op, n_args, 2);
                        write_strobe(a, b);
                    end
                    "D":
                    begin
                        n_args = $fscanf(fd, "%d", a);
                        fields_check(op, n_args, 1);
                        drop_lock(a);
                    end
                    "Z":
                    begin
                        for (int ch = 0; ch < NUM_CH; ch++)
                            for (int rg = 0; rg < REGS_PER_CH; rg++)
                                read_check(ch, rg, '0);
                    end
                    "T":
                    begin
                        n_args = $fscanf(fd, "%d", a);
                        fields_check(op, n_args, 1);
                        tests++;
                        $display("test %0d: %0d checks, %0d errors", a,
                                 checks - mark_checks, errors - mark_errors);
                        mark_checks = checks;
                        mark_errors = errors;
                    end
                    "#":
                        void'($fgets(line, fd));
                    default:
                    begin
                        $display("Error: unknown pattern operation '%c'", op);
                        errors++;
                        void'($fgets(line, fd));
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // Watchdog budget from the wait counts and the line count of the file
    initial
    begin
        logic [7:0]       c;
        logic [8*128-1:0] line;
        int               fd;
        int               n;
        int               waits;
        int               lines;

        waits = 0;
        lines = 0;
        fd = $fopen("testbench/clk_mon_patterns.txt", "r");
        if (fd != 0)
        begin
            while ($fscanf(fd, " %c", c) == 1)
            begin
                lines++;
                if (c == "W")
                begin
                    if ($fscanf(fd, "%d", n) == 1)
                        waits += n;
                end
                void'($fgets(line, fd));
            end
            $fclose(fd);
        end
        repeat (waits + 100 * lines + 100) @(posedge clk_ref);
        $display("Error: watchdog expired before the patterns finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
